//--- sys_ctl.f
source/sys_ctl_pkg.sv
source/timer_ctl_if.sv
source/timer_bank.sv
source/sys_regs.sv
source/cpu_throttle.sv
source/sys_ctl.sv
dv/sys_ctl_tb.sv

//--- dv/sys_ctl_tb.sv
module sys_ctl_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import sys_ctl_pkg::*;

   localparam int NUM_TIMERS = 8;

   logic        sys_clk;
   logic        reset_n;
   logic [15:0] addr;
   logic [7:0]  wr_data;
   logic        wr_en;
   logic        rd_req;
   logic [7:0]  rd_data;
   logic        rd_valid;
   logic        irq_n;
   logic        cpu_clk_en;

   logic [15:0] lfsr_state;
   int          value_errors;
   int          bus_errors;
   int          timeout_errors;
   logic [19:0] ticks_model [NUM_TIMERS];

   sys_ctl #(
      .NUM_TIMERS(NUM_TIMERS),
      .TICK_WIDTH(TICK_WIDTH_DEF)
   ) dut (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .addr       (addr),
      .wr_data    (wr_data),
      .wr_en      (wr_en),
      .rd_req     (rd_req),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .irq_n      (irq_n),
      .cpu_clk_en (cpu_clk_en)
   );

   always #4 sys_clk = ~sys_clk;  // 8 ns period

   // bus timing, a hit answers exactly one cycle later and a miss never does
   a_hit_read_valid: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      (rd_req && addr[15:8] == SYS_PAGE) |=> rd_valid
   ) else begin
      $display("rd_valid did not follow a read inside the page");
      bus_errors++;
   end

   a_miss_read_quiet: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      (rd_req && addr[15:8] != SYS_PAGE) |=> !rd_valid
   ) else begin
      $display("rd_valid answered a read outside the page");
      bus_errors++;
   end

   a_valid_has_cause: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      rd_valid |-> $past(rd_req && addr[15:8] == SYS_PAGE)
   ) else begin
      $display("rd_valid rose without a read one cycle before");
      bus_errors++;
   end

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [15:0] reg_addr(input logic [7:0] offset);
      return {SYS_PAGE, offset};
   endfunction

   task automatic check_value(input string test, input logic [31:0] expected, actual);
      assert (expected == actual)
      else begin
         $display("[ERROR] %s expected 0x%0h actual 0x%0h", test, expected, actual);
         value_errors++;
      end
   endtask

   task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
      @(negedge sys_clk);
      addr    = a;
      wr_data = d;
      wr_en   = 1'b1;
      @(negedge sys_clk);
      wr_en = 1'b0;
   endtask

   task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
      int waited;
      @(negedge sys_clk);
      addr   = a;
      rd_req = 1'b1;
      @(negedge sys_clk);
      rd_req = 1'b0;
      waited = 0;
      while (!rd_valid && waited < 8) begin
         @(negedge sys_clk);
         waited++;
      end
      if (!rd_valid) begin
         $display("no rd_valid within 8 cycles of a read of 0x%h", a);
         timeout_errors++;
      end
      d = rd_data;
   endtask

   task automatic expect_no_response(input logic [15:0] a);
      int waited;
      @(negedge sys_clk);
      addr   = a;
      rd_req = 1'b1;
      @(negedge sys_clk);
      rd_req = 1'b0;
      waited = 0;
      while (!rd_valid && waited < 4) begin
         @(negedge sys_clk);
         waited++;
      end
      if (rd_valid) begin
         $display("read of 0x%h outside the page got an answer", a);
         bus_errors++;
      end
   endtask

   task automatic read_value(output logic [19:0] v);
      logic [7:0] b;
      bus_read(reg_addr(REG_TICKS_LO), b);
      v[7:0] = b;
      bus_read(reg_addr(REG_TICKS_MID), b);
      v[15:8] = b;
      bus_read(reg_addr(REG_TICKS_HI), b);
      v[19:16] = b[3:0];
   endtask

   task automatic arm_timer(input int t, input logic [7:0] reload);
      bus_write(reg_addr(REG_INDEX), 8'(t));
      bus_write(reg_addr(REG_TICKS_LO), reload);
      bus_write(reg_addr(REG_TICKS_MID), 8'h00);
      bus_write(reg_addr(REG_TICKS_HI), 8'h00);
      bus_write(reg_addr(REG_LOAD), 8'h00);
      bus_write(reg_addr(REG_ENABLE), 8'h01);
   endtask

   task automatic wait_irq_n(input logic level, input int limit);
      int waited;
      waited = 0;
      while (irq_n !== level && waited < limit) begin
         @(negedge sys_clk);
         waited++;
      end
      if (irq_n !== level) begin
         $display("irq_n did not go to %b within %0d cycles", level, limit);
         timeout_errors++;
      end
   endtask

   task automatic poll_status(input logic [7:0] expected, input int limit);
      logic [7:0] got;
      int         tries;
      tries = 0;
      bus_read(reg_addr(REG_IRQ), got);
      while (got !== expected && tries < limit) begin
         bus_read(reg_addr(REG_IRQ), got);
         tries++;
      end
      check_value("irq status", expected, got);
   endtask

   initial begin
      logic [7:0]  rd;
      logic [19:0] val;
      logic [7:0]  spd;
      logic [15:0] miss;
      logic [7:0]  off;
      int          idx_a;
      int          idx_b;
      int          pulses;
      int          divisor;
      sys_clk        = 1'b0;
      reset_n        = 1'b0;
      addr           = '0;
      wr_data        = '0;
      wr_en          = 1'b0;
      rd_req         = 1'b0;
      lfsr_state     = 16'd26;
      value_errors   = 0;
      bus_errors     = 0;
      timeout_errors = 0;
      repeat (2) @(posedge sys_clk);
      @(negedge sys_clk);
      reset_n = 1'b1;

      // reset values and read-back
      check_value("reset irq_n", 1, irq_n);
      check_value("reset cpu_clk_en", 1, cpu_clk_en);
      bus_read(reg_addr(REG_SPEED), rd);
      check_value("reset speed", 0, rd);
      bus_read(reg_addr(REG_INDEX), rd);
      check_value("reset index", 0, rd);
      spd = 8'(rand_bits(3));
      bus_write(reg_addr(REG_SPEED), spd);
      bus_read(reg_addr(REG_SPEED), rd);
      check_value("speed read-back", spd, rd);
      for (int t = 0; t < NUM_TIMERS; t++) begin
         ticks_model[t]     = 20'(rand_bits(20));
         ticks_model[t][16] = 1'b1;  // keeps the count far from zero
         bus_write(reg_addr(REG_INDEX), 8'(t));
         bus_read(reg_addr(REG_INDEX), rd);
         check_value("index read-back", t, rd);
         bus_write(reg_addr(REG_TICKS_LO), ticks_model[t][7:0]);
         bus_write(reg_addr(REG_TICKS_MID), ticks_model[t][15:8]);
         bus_write(reg_addr(REG_TICKS_HI), {4'h0, ticks_model[t][19:16]});
      end

      // load, each index keeps its own staged ticks
      for (int t = 0; t < NUM_TIMERS; t++) begin
         bus_write(reg_addr(REG_INDEX), 8'(t));
         read_value(val);
         check_value($sformatf("value before load, timer %0d", t), 0, val);
         bus_write(reg_addr(REG_LOAD), 8'h00);
         read_value(val);
         check_value($sformatf("value after load, timer %0d", t), ticks_model[t], val);
         bus_write(reg_addr(REG_ENABLE), 8'h01);
         bus_read(reg_addr(REG_ENABLE), rd);
         check_value("enable set", 1, rd);
         bus_write(reg_addr(REG_ENABLE), 8'h00);
         bus_read(reg_addr(REG_ENABLE), rd);
         check_value("enable clear", 0, rd);
      end

      // expiry, interrupt and acknowledge on two timers
      idx_a = int'(rand_bits(3));
      idx_b = (idx_a + 1 + int'(rand_bits(2))) % NUM_TIMERS;
      arm_timer(idx_a, 8'(2 + rand_bits(4)));
      arm_timer(idx_b, 8'(2 + rand_bits(4)));
      wait_irq_n(1'b0, 64);
      poll_status((8'h80 >> idx_a) | (8'h80 >> idx_b), 16);
      bus_write(reg_addr(REG_INDEX), 8'(idx_a));
      bus_write(reg_addr(REG_ENABLE), 8'h00);
      bus_write(reg_addr(REG_INDEX), 8'(idx_b));
      bus_write(reg_addr(REG_ENABLE), 8'h00);
      bus_write(reg_addr(REG_INDEX), 8'(idx_a));
      bus_write(reg_addr(REG_IRQ), 8'h00);
      bus_read(reg_addr(REG_IRQ), rd);
      check_value("status after first ack", 8'h80 >> idx_b, rd);
      check_value("irq_n with one flag left", 0, irq_n);
      bus_write(reg_addr(REG_INDEX), 8'(idx_b));
      bus_write(reg_addr(REG_IRQ), 8'h00);
      bus_read(reg_addr(REG_IRQ), rd);
      check_value("status after last ack", 0, rd);
      wait_irq_n(1'b1, 8);

      // throttle, pulse count over a 64 cycle window
      for (int code = 0; code < 8; code++) begin
         bus_write(reg_addr(REG_SPEED), 8'(code));
         repeat (32) @(negedge sys_clk);  // settle time for a new code
         pulses = 0;
         for (int c = 0; c < 64; c++) begin
            @(negedge sys_clk);
            if (cpu_clk_en) pulses++;
         end
         divisor = (code >= 5) ? 32 : (1 << code);
         check_value($sformatf("throttle code %0d", code), 64 / divisor, pulses);
      end
      bus_write(reg_addr(REG_SPEED), 8'(SPEED_FULL));

      // page decode, every real offset once from a wrong page
      bus_write(reg_addr(REG_INDEX), 8'h00);
      for (int n = 0; n < 8; n++) begin
         miss = 16'(rand_bits(16));
         if (miss[15:8] == SYS_PAGE) miss[8] = ~miss[8];
         miss[7:0] = 8'(n);  // real offset, wrong page
         bus_write(miss, 8'hFF);  // all ones, unlike speed, index and enable now
         expect_no_response(miss);
      end
      bus_read(reg_addr(REG_SPEED), rd);
      check_value("speed after misses", 0, rd);
      bus_read(reg_addr(REG_INDEX), rd);
      check_value("index after misses", 0, rd);
      bus_read(reg_addr(REG_ENABLE), rd);
      check_value("enable after misses", 0, rd);
      check_value("irq_n after misses", 1, irq_n);
      for (int n = 0; n < 4; n++) begin
         off = 8'(rand_bits(8));
         if (off < 8'h08) off = off | 8'h08;
         bus_read(reg_addr(off), rd);
         check_value($sformatf("unused offset 0x%0h", off), 0, rd);
      end
      bus_read(reg_addr(REG_LOAD), rd);
      check_value("load offset read", 0, rd);

      repeat (2) @(negedge sys_clk);
      $display("errors: value %0d, bus %0d, timeout %0d",
               value_errors, bus_errors, timeout_errors);
      if (value_errors + bus_errors + timeout_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- source/sys_ctl.sv
module sys_ctl #(
   parameter int NUM_TIMERS = 8,
   parameter int TICK_WIDTH = sys_ctl_pkg::TICK_WIDTH_DEF
) (
   input  logic        sys_clk,
   input  logic        reset_n,
   input  logic [15:0] addr,
   input  logic [7:0]  wr_data,
   input  logic        wr_en,
   input  logic        rd_req,
   output logic [7:0]  rd_data,
   output logic        rd_valid,
   output logic        irq_n,
   output logic        cpu_clk_en
);

   import sys_ctl_pkg::*;

   cpu_speed_e speed;  // register block to throttle

   timer_ctl_if #(
      .NUM_TIMERS(NUM_TIMERS),
      .TICK_WIDTH(TICK_WIDTH)
   ) tctl ();

   sys_regs #(
      .NUM_TIMERS(NUM_TIMERS),
      .TICK_WIDTH(TICK_WIDTH)
   ) u_regs (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .addr     (addr),
      .wr_data  (wr_data),
      .wr_en    (wr_en),
      .rd_req   (rd_req),
      .rd_data  (rd_data),
      .rd_valid (rd_valid),
      .irq_n    (irq_n),
      .speed    (speed),
      .tctl     (tctl.regs)
   );

   timer_bank #(
      .NUM_TIMERS(NUM_TIMERS),
      .TICK_WIDTH(TICK_WIDTH)
   ) u_timers (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .tctl    (tctl.bank)
   );

   cpu_throttle u_throttle (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .speed      (speed),
      .cpu_clk_en (cpu_clk_en)
   );

endmodule

//--- source/cpu_throttle.sv
module cpu_throttle (
   input  logic                    sys_clk,
   input  logic                    reset_n,
   input  sys_ctl_pkg::cpu_speed_e speed,
   output logic                    cpu_clk_en
);

   import sys_ctl_pkg::*;

   logic [4:0] count;  // free running
   logic [4:0] mask;
   logic       hit;

   // low count bits that must be zero for a pulse
   always_comb begin
      case (speed)
         SPEED_FULL:      mask = 5'b00000;
         SPEED_HALF:      mask = 5'b00001;
         SPEED_QUARTER:   mask = 5'b00011;
         SPEED_EIGHTH:    mask = 5'b00111;
         SPEED_SIXTEENTH: mask = 5'b01111;
         default:         mask = 5'b11111;  // slowest, divide by 32
      endcase
   end

   assign hit = (count & mask) == '0;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // registered so every speed pulses on the same counter phase
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         cpu_clk_en <= 1'b1;
      end else begin
         cpu_clk_en <= hit;
      end
   end

   a_full_speed_high: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      speed == SPEED_FULL |=> cpu_clk_en
   ) else $error("cpu_clk_en dropped at full speed");

endmodule

//--- source/sys_regs.sv
module sys_regs #(
   parameter int NUM_TIMERS = sys_ctl_pkg::MAX_TIMERS,
   parameter int TICK_WIDTH = sys_ctl_pkg::TICK_WIDTH_DEF
) (
   input  logic                    sys_clk,
   input  logic                    reset_n,
   input  logic [15:0]             addr,
   input  logic [7:0]              wr_data,
   input  logic                    wr_en,
   input  logic                    rd_req,
   output logic [7:0]              rd_data,
   output logic                    rd_valid,
   output logic                    irq_n,
   output sys_ctl_pkg::cpu_speed_e speed,
   timer_ctl_if.regs               tctl
);

   import sys_ctl_pkg::*;

   logic                                  page_hit;
   sys_reg_e                              offset;
   logic                                  wr_hit;
   logic                                  rd_hit;
   logic                                  index_ok;
   logic [INDEX_WIDTH-1:0]                index;
   logic [NUM_TIMERS-1:0][TICK_WIDTH-1:0] ticks;
   logic [NUM_TIMERS-1:0]                 enable;
   logic [NUM_TIMERS-1:0]                 load;
   logic [NUM_TIMERS-1:0]                 ack;
   logic [TICK_WIDTH_DEF-1:0]             ticks_wide;
   logic [TICK_WIDTH_DEF-1:0]             value_wide;
   logic [7:0]                            irq_status;
   logic [7:0]                            rd_mux;

   assign page_hit = addr[15:8] == SYS_PAGE;
   assign offset   = sys_reg_e'(addr[7:0]);
   assign wr_hit   = wr_en && page_hit;
   assign rd_hit   = rd_req && page_hit;
   assign index_ok = int'(index) < NUM_TIMERS;  // upper indices are dead

   // staged ticks of the current index with one byte swapped in
   always_comb begin
      ticks_wide = TICK_WIDTH_DEF'(ticks[index]);
      case (offset)
         REG_TICKS_LO:  ticks_wide[7:0]  = wr_data;
         REG_TICKS_MID: ticks_wide[15:8] = wr_data;
         REG_TICKS_HI:  ticks_wide[TICK_WIDTH_DEF-1:16] = wr_data[TICKS_HI_BITS-1:0];
         default: ;
      endcase
   end

   // timer 0 lands in bit 7 for the CPU bit instruction
   always_comb begin
      irq_status = '0;
      for (int t = 0; t < NUM_TIMERS; t++) begin
         irq_status[7 - t] = tctl.irq[t];
      end
   end

   always_comb begin
      value_wide = TICK_WIDTH_DEF'(tctl.value[index]);
      rd_mux     = '0;
      case (offset)
         REG_SPEED:     rd_mux = {5'b0, speed};
         REG_INDEX:     rd_mux = {{(8 - INDEX_WIDTH){1'b0}}, index};
         REG_TICKS_LO:  if (index_ok) rd_mux = value_wide[7:0];
         REG_TICKS_MID: if (index_ok) rd_mux = value_wide[15:8];
         REG_TICKS_HI: begin
            if (index_ok) begin
               rd_mux = {{(8 - TICKS_HI_BITS){1'b0}}, value_wide[TICK_WIDTH_DEF-1:16]};
            end
         end
         REG_ENABLE:    if (index_ok) rd_mux = {7'b0, enable[index]};
         REG_IRQ:       rd_mux = irq_status;
         default: ;  // load and unused offsets read zero
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         speed  <= SPEED_FULL;
         index  <= '0;
         ticks  <= '0;
         enable <= '0;
         load   <= '0;
         ack    <= '0;
      end else begin
         load <= '0;  // strobes last one cycle
         ack  <= '0;
         if (wr_hit) begin
            case (offset)
               REG_SPEED: speed <= cpu_speed_e'(wr_data[2:0]);
               REG_INDEX: index <= wr_data[INDEX_WIDTH-1:0];
               REG_TICKS_LO, REG_TICKS_MID, REG_TICKS_HI: begin
                  if (index_ok) ticks[index] <= TICK_WIDTH'(ticks_wide);
               end
               REG_LOAD:   if (index_ok) load[index] <= 1'b1;
               REG_ENABLE: if (index_ok) enable[index] <= wr_data[0];
               REG_IRQ:    if (index_ok) ack[index] <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rd_valid <= 1'b0;
         irq_n    <= 1'b1;
      end else begin
         rd_valid <= rd_hit;
         irq_n    <= ~|tctl.irq;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rd_hit) rd_data <= rd_mux;
   end

   assign tctl.enable = enable;
   assign tctl.load   = load;
   assign tctl.ack    = ack;
   assign tctl.ticks  = ticks;

   a_no_rd_wr_overlap: assert property (
      @(posedge sys_clk) disable iff (!reset_n)
      !(wr_en && rd_req)
   ) else $error("write and read strobes overlap at addr %h", addr);

endmodule

//--- source/timer_bank.sv
module timer_bank #(
   parameter int NUM_TIMERS = sys_ctl_pkg::MAX_TIMERS,
   parameter int TICK_WIDTH = sys_ctl_pkg::TICK_WIDTH_DEF
) (
   input  logic      sys_clk,
   input  logic      reset_n,
   timer_ctl_if.bank tctl
);

   // one down-counter per timer
   // an enabled counter at zero reloads and flags, so the period is ticks+1
   for (genvar t = 0; t < NUM_TIMERS; t++) begin : g_timer

      logic [TICK_WIDTH-1:0] count;
      logic [TICK_WIDTH-1:0] loaded;  // what went into count last
      logic                  irq_flag;
      logic                  expire;

      assign expire = tctl.enable[t] && (count == '0);

      always_ff @(posedge sys_clk) begin
         if (!reset_n) begin
            count  <= '0;
            loaded <= '0;
         end else if (tctl.load[t] || expire) begin
            count  <= tctl.ticks[t];
            loaded <= tctl.ticks[t];
         end else if (tctl.enable[t]) begin
            count <= count - 1'b1;
         end
      end

      always_ff @(posedge sys_clk) begin
         if (!reset_n) begin
            irq_flag <= 1'b0;
         end else if (expire) begin
            irq_flag <= 1'b1;  // set beats a same-cycle ack
         end else if (tctl.ack[t]) begin
            irq_flag <= 1'b0;
         end
      end

      assign tctl.value[t] = count;
      assign tctl.irq[t]   = irq_flag;

      // counting never climbs above the last reload, whatever ticks does meanwhile
      a_value_bounded: assert property (
         @(posedge sys_clk) disable iff (!reset_n)
         count <= loaded
      ) else $error("timer %0d count %0h above reload %0h", t, count, loaded);

   end

endmodule

//--- source/timer_ctl_if.sv
interface timer_ctl_if #(
   parameter int NUM_TIMERS = sys_ctl_pkg::MAX_TIMERS,
   parameter int TICK_WIDTH = sys_ctl_pkg::TICK_WIDTH_DEF
);

   logic [NUM_TIMERS-1:0]                 enable;  // level per timer
   logic [NUM_TIMERS-1:0]                 load;    // one-cycle strobe
   logic [NUM_TIMERS-1:0]                 ack;     // one-cycle strobe
   logic [NUM_TIMERS-1:0][TICK_WIDTH-1:0] ticks;   // staged reload values
   logic [NUM_TIMERS-1:0][TICK_WIDTH-1:0] value;   // live counts
   logic [NUM_TIMERS-1:0]                 irq;     // sticky flags

   modport regs (
      output enable,
      output load,
      output ack,
      output ticks,
      input  value,
      input  irq
   );

   modport bank (
      input  enable,
      input  load,
      input  ack,
      input  ticks,
      output value,
      output irq
   );

endinterface

//--- source/sys_ctl_pkg.sv
package sys_ctl_pkg;

   // this block answers on CPU page 0x93XX
   localparam logic [7:0] SYS_PAGE = 8'h93;

   // reload value width and timer addressing
   localparam int TICK_WIDTH_DEF = 20;
   localparam int MAX_TIMERS     = 8;
   localparam int INDEX_WIDTH    = $clog2(MAX_TIMERS);   // index register bits
   localparam int TICKS_HI_BITS  = TICK_WIDTH_DEF - 16;  // bits behind REG_TICKS_HI

   // register offsets, low address byte
   typedef enum logic [7:0] {
      REG_SPEED     = 8'h00,
      REG_INDEX     = 8'h01,
      REG_TICKS_LO  = 8'h02,  // write stages ticks, read gives current value
      REG_TICKS_MID = 8'h03,
      REG_TICKS_HI  = 8'h04,  // low nibble only
      REG_LOAD      = 8'h05,  // write-only command
      REG_ENABLE    = 8'h06,  // bit 0
      REG_IRQ       = 8'h07   // write acks, read gives status
   } sys_reg_e;

   // CPU speed codes, divisor is 2**code
   // codes 5 to 7 all fall back to a divisor of 32
   typedef enum logic [2:0] {
      SPEED_FULL      = 3'd0,
      SPEED_HALF      = 3'd1,
      SPEED_QUARTER   = 3'd2,
      SPEED_EIGHTH    = 3'd3,
      SPEED_SIXTEENTH = 3'd4
   } cpu_speed_e;

endpackage
